// File: decode_stage.f
+incdir+logic
logic/decode_pkg.sv
logic/slot_decoder.sv
logic/pair_packer.sv
logic/decode_queue.sv
logic/decode_stage.sv
tests/decode_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f decode_stage.f \
  --top-module decode_stage_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdecode_stage_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q -F '*** PASSED ***'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tests/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage_tb
  import decode_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  // one stimulus row with the packet expected at the queue output
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [1:0]  mask;
    logic [1:0]  emask;
    logic [31:0] epc0;
    logic [31:0] epc1;
    decode_rec_t erec0;
    decode_rec_t erec1;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        fetch_valid;
  logic        fetch_ready;
  logic [31:0] fetch_pc;
  logic [31:0] inst0;
  logic [31:0] inst1;
  logic [1:0]  fetch_mask;
  logic        pkt_valid;
  logic        pkt_ready;
  logic [1:0]  pkt_mask;
  logic [31:0] pkt_pc0;
  logic [31:0] pkt_pc1;
  decode_rec_t pkt_rec0;
  decode_rec_t pkt_rec1;

  row_t        rows[$];
  int          exp_q[$];
  logic [31:0] rng_state;
  int          hold_cycles;
  int          stall_seen;
  int          n_main;

  decode_stage UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .fetch_pc_i    (fetch_pc),
    .fetch_inst0_i (inst0),
    .fetch_inst1_i (inst1),
    .fetch_mask_i  (fetch_mask),
    .pkt_valid_o   (pkt_valid),
    .pkt_ready_i   (pkt_ready),
    .pkt_mask_o    (pkt_mask),
    .pkt_pc0_o     (pkt_pc0),
    .pkt_pc1_o     (pkt_pc1),
    .pkt_rec0_o    (pkt_rec0),
    .pkt_rec1_o    (pkt_rec1)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] add_word(input logic [4:0] rd, rj, rk);
    return {17'h00020, rk, rj, rd};
  endfunction

  function automatic logic [31:0] imm_word(input logic [9:0] opc, input logic [11:0] imm,
                                           input logic [4:0] rj, rd);
    return {opc, imm, rj, rd};
  endfunction

  // offset bits 15..0 go to 25..10, bits 25..16 to 9..0
  function automatic logic [31:0] bl_word(input logic [25:0] offs);
    return {6'h15, offs[15:0], offs[25:16]};
  endfunction

  function automatic decode_rec_t make_rec(input op_class_t op, input logic [31:0] imm,
                                           input logic [4:0] r0, r1, w, input logic ine);
    return {op, imm, r0, r1, w, ine};
  endfunction

  // mask 10 moves slot 1 down, other masks keep both slots
  task automatic add_row(input logic [31:0] pc, w0, w1, input logic [1:0] mask,
                         input decode_rec_t d0, d1);
    if (mask == 2'b10)
      rows.push_back('{pc, w0, w1, mask, 2'b01, pc | 32'h4, 32'h0, d1, '0});
    else
      rows.push_back('{pc, w0, w1, mask, mask, pc, pc | 32'h4, d0, d1});
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rec(input string name, input decode_rec_t got, input decode_rec_t exp);
    if (got !== exp)
      report_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_mask(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      report_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [11:0] imm;
    add_row(32'h1000_0000, add_word(5'd3, 5'd4, 5'd5), imm_word(10'h00A, 12'hFFB, 5'd7, 5'd6),
            2'b11, make_rec(OP_ADD, 32'h0, 5'd5, 5'd4, 5'd3, 1'b0),
            make_rec(OP_ADDI, 32'hFFFF_FFFB, 5'd0, 5'd7, 5'd6, 1'b0));
    add_row(32'h1000_0008, imm_word(10'h0A2, 12'h7FC, 5'd9, 5'd8),
            imm_word(10'h0A6, 12'hFF0, 5'd11, 5'd10), 2'b11,
            make_rec(OP_LOAD, 32'h0000_07FC, 5'd0, 5'd9, 5'd8, 1'b0),
            make_rec(OP_STORE, 32'hFFFF_FFF0, 5'd10, 5'd11, 5'd0, 1'b0));
    // bl offset -3 words, then an illegal word
    add_row(32'h1000_0010, bl_word(26'h3FF_FFFD), 32'hFFFF_FFFF, 2'b11,
            make_rec(OP_BL, 32'hFFFF_FFF4, 5'd0, 5'd0, 5'd1, 1'b0),
            make_rec(OP_ILLEGAL, 32'h0, 5'd0, 5'd0, 5'd0, 1'b1));
    add_row(32'h1000_0018, 32'h0000_0000, bl_word(26'h001_2345), 2'b10,
            make_rec(OP_ILLEGAL, 32'h0, 5'd0, 5'd0, 5'd0, 1'b1),
            make_rec(OP_BL, 32'h0004_8D14, 5'd0, 5'd0, 5'd1, 1'b0));
    add_row(32'h1000_0020, add_word(5'd1, 5'd1, 5'd1), add_word(5'd2, 5'd2, 5'd2), 2'b00,
            make_rec(OP_ADD, 32'h0, 5'd1, 5'd1, 5'd1, 1'b0),
            make_rec(OP_ADD, 32'h0, 5'd2, 5'd2, 5'd2, 1'b0));
    add_row(32'h1000_0028, add_word(5'd1, 5'd2, 5'd3), imm_word(10'h00A, 12'h123, 5'd31, 5'd30),
            2'b01, make_rec(OP_ADD, 32'h0, 5'd3, 5'd2, 5'd1, 1'b0),
            make_rec(OP_ADDI, 32'h0000_0123, 5'd0, 5'd31, 5'd30, 1'b0));
    for (int k = 0; k < 16; k++)
    begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      imm = r[26:15];
      add_row(32'h2000_0000 + 32'(k * 8), add_word(r[4:0], r[9:5], r[14:10]),
              imm_word(10'h0A2, imm, r[9:5], r[4:0]), r[31:30],
              make_rec(OP_ADD, 32'h0, r[14:10], r[9:5], r[4:0], 1'b0),
              make_rec(OP_LOAD, {{20{imm[11]}}, imm}, 5'd0, r[9:5], r[4:0], 1'b0));
    end
    n_main = rows.size();
    // flush rows: three flushed, one offered during flush, one after
    for (int k = 0; k < 5; k++)
      add_row(32'h3000_0000 + 32'(k * 8), add_word(5'(k + 1), 5'd2, 5'd3), 32'hFFFF_FFFF,
              2'b11, make_rec(OP_ADD, 32'h0, 5'd3, 5'd2, 5'(k + 1), 1'b0),
              make_rec(OP_ILLEGAL, 32'h0, 5'd0, 5'd0, 5'd0, 1'b1));
  endtask

  task automatic present_row(input int idx);
    fetch_pc   = rows[idx].pc;
    inst0      = rows[idx].w0;
    inst1      = rows[idx].w1;
    fetch_mask = rows[idx].mask;
  endtask

  // returns on the falling edge after the packet was taken
  task automatic drive_row(input int idx);
    int waited;
    waited = 0;
    present_row(idx);
    fetch_valid = 1'b1;
    while (!fetch_ready)
    begin
      if (int'(UUT.u_queue.count) != `DQ_DEPTH)
        report_failure("fetch_ready_o went low while the decode queue was not full");
      stall_seen++;
      waited++;
      if (waited > WAIT_LIMIT)
        report_failure("timeout waiting for fetch_ready_o");
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic collect_packets(input int n);
    int got;
    int idle;
    int idx;
    got = 0;
    idle = 0;
    while (got < n)
    begin
      @(negedge clk);
      rng_state = xorshift(rng_state);
      pkt_ready = (hold_cycles > 0) ? 1'b0 : rng_state[7];
      if (hold_cycles > 0)
        hold_cycles--;
      if (pkt_valid && pkt_ready)
      begin
        idx = exp_q.pop_front();
        check_mask("pkt_mask_o", pkt_mask, rows[idx].emask);
        check_pc("pkt_pc0_o", pkt_pc0, rows[idx].epc0);
        check_pc("pkt_pc1_o", pkt_pc1, rows[idx].epc1);
        check_rec("pkt_rec0_o", pkt_rec0, rows[idx].erec0);
        check_rec("pkt_rec1_o", pkt_rec1, rows[idx].erec1);
        got++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > WAIT_LIMIT)
          report_failure("timeout waiting for a packet on pkt_valid_o");
      end
    end
  endtask

  initial
  begin
    rst_n = 1'b0;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    inst0 = '0;
    inst1 = '0;
    fetch_mask = '0;
    pkt_ready = 1'b0;
    rng_state = 32'd77;
    hold_cycles = 0;
    stall_seen = 0;
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("pkt_valid_o", pkt_valid, 1'b0);
    check_flag("fetch_ready_o", fetch_ready, 1'b1);

    for (int i = 0; i < n_main; i++)
      if (rows[i].mask != 2'b00)
        exp_q.push_back(i);
    // backend stalls first so the queue fills
    hold_cycles = 4 * `DQ_DEPTH;
    fork
      begin
        for (int i = 0; i < n_main; i++)
          drive_row(i);
        fetch_valid = 1'b0;
      end
      collect_packets(exp_q.size());
    join
    if (stall_seen == 0)
      report_failure("back-pressure never pulled fetch_ready_o low");
    @(negedge clk);
    pkt_ready = 1'b0;
    check_flag("pkt_valid_o", pkt_valid, 1'b0);

    for (int i = 0; i < 3; i++)
      drive_row(n_main + i);
    check_flag("pkt_valid_o", pkt_valid, 1'b1);
    flush = 1'b1;
    present_row(n_main + 3);
    fetch_valid = 1'b1;
    @(negedge clk);
    check_flag("pkt_valid_o", pkt_valid, 1'b0);
    flush = 1'b0;
    fetch_valid = 1'b0;
    @(negedge clk);
    check_flag("fetch_ready_o", fetch_ready, 1'b1);
    check_flag("pkt_valid_o", pkt_valid, 1'b0);
    exp_q.push_back(n_main + 4);
    fork
      begin
        drive_row(n_main + 4);
        fetch_valid = 1'b0;
      end
      collect_packets(1);
    join
    repeat (8)
    begin
      @(negedge clk);
      check_flag("pkt_valid_o", pkt_valid, 1'b0);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import decode_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        fetch_valid_i,
  output logic        fetch_ready_o,
  input  logic [31:0] fetch_pc_i,
  input  logic [31:0] fetch_inst0_i,
  input  logic [31:0] fetch_inst1_i,
  input  logic [1:0]  fetch_mask_i,
  output logic        pkt_valid_o,
  input  logic        pkt_ready_i,
  output logic [1:0]  pkt_mask_o,
  output logic [31:0] pkt_pc0_o,
  output logic [31:0] pkt_pc1_o,
  output decode_rec_t pkt_rec0_o,
  output decode_rec_t pkt_rec1_o
);

  decode_rec_t dec_rec0;
  decode_rec_t dec_rec1;
  logic        push_valid;
  logic        push_ready;
  logic [1:0]  push_mask;
  logic [31:0] push_pc0;
  logic [31:0] push_pc1;
  decode_rec_t push_rec0;
  decode_rec_t push_rec1;

  slot_decoder u_dec0 (
    .inst_i (fetch_inst0_i),
    .rec_o  (dec_rec0)
  );

  slot_decoder u_dec1 (
    .inst_i (fetch_inst1_i),
    .rec_o  (dec_rec1)
  );

  pair_packer u_packer (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .valid_i (fetch_valid_i),
    .ready_o (fetch_ready_o),
    .pc_i    (fetch_pc_i),
    .mask_i  (fetch_mask_i),
    .rec0_i  (dec_rec0),
    .rec1_i  (dec_rec1),
    .valid_o (push_valid),
    .ready_i (push_ready),
    .mask_o  (push_mask),
    .pc0_o   (push_pc0),
    .pc1_o   (push_pc1),
    .rec0_o  (push_rec0),
    .rec1_o  (push_rec1)
  );

  decode_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .push_mask_i  (push_mask),
    .push_pc0_i   (push_pc0),
    .push_pc1_i   (push_pc1),
    .push_rec0_i  (push_rec0),
    .push_rec1_i  (push_rec1),
    .pop_valid_o  (pkt_valid_o),
    .pop_ready_i  (pkt_ready_i),
    .pop_mask_o   (pkt_mask_o),
    .pop_pc0_o    (pkt_pc0_o),
    .pop_pc1_o    (pkt_pc1_o),
    .pop_rec0_o   (pkt_rec0_o),
    .pop_rec1_o   (pkt_rec1_o)
  );

endmodule

// File: logic/decode_queue.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_queue
  import decode_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        push_valid_i,
  output logic        push_ready_o,
  input  logic [1:0]  push_mask_i,
  input  logic [31:0] push_pc0_i,
  input  logic [31:0] push_pc1_i,
  input  decode_rec_t push_rec0_i,
  input  decode_rec_t push_rec1_i,
  output logic        pop_valid_o,
  input  logic        pop_ready_i,
  output logic [1:0]  pop_mask_o,
  output logic [31:0] pop_pc0_o,
  output logic [31:0] pop_pc1_o,
  output decode_rec_t pop_rec0_o,
  output decode_rec_t pop_rec1_o
);

  localparam int ENTRY_W = 2 + 32 + 32 + 2 * $bits(decode_rec_t);
  localparam logic [`DQ_PTR_W-1:0] PTR_ONE = 1;

  logic [ENTRY_W-1:0]   mem [`DQ_DEPTH];
  logic [ENTRY_W-1:0]   push_entry;
  logic [ENTRY_W-1:0]   out_q;
  logic [`DQ_PTR_W-1:0] wr_ptr;
  logic [`DQ_PTR_W-1:0] rd_ptr;
  logic [`DQ_PTR_W:0]   count;
  logic                 push_fire;
  logic                 pop_fire;
  logic                 out_load;
  logic                 mem_wr;
  logic                 mem_rd;

  assign push_entry = {push_mask_i, push_pc0_i, push_pc1_i, push_rec0_i, push_rec1_i};
  assign {pop_mask_o, pop_pc0_o, pop_pc1_o, pop_rec0_o, pop_rec1_o} = out_q;

  assign push_ready_o = (count != `DQ_DEPTH);
  assign push_fire = push_valid_i && push_ready_o;
  assign pop_fire  = pop_valid_o && pop_ready_i;

  // output register free this edge
  assign out_load = !pop_valid_o || pop_fire;

  // empty buffer lets a push go straight to the output
  assign mem_rd = out_load && (count != '0);
  assign mem_wr = push_fire && !(out_load && (count == '0));

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      pop_valid_o <= 1'b0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
    end
    else
    begin
      if (out_load)
        pop_valid_o <= mem_rd || push_fire;
      if (mem_wr)
        wr_ptr <= wr_ptr + PTR_ONE;
      if (mem_rd)
        rd_ptr <= rd_ptr + PTR_ONE;
      count <= count + {{`DQ_PTR_W{1'b0}}, mem_wr} - {{`DQ_PTR_W{1'b0}}, mem_rd};
    end
  end

  always_ff @(posedge clk)
  begin
    if (mem_wr)
      mem[wr_ptr] <= push_entry;
    if (mem_rd)
      out_q <= mem[rd_ptr];
    else if (out_load && push_fire)
      out_q <= push_entry;
  end

  // write pointer leads the read pointer by the count
  a_ptr_count : assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_ptr - rd_ptr) == count[`DQ_PTR_W-1:0]
  );

  a_count_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= `DQ_DEPTH
  );

endmodule

// File: logic/pair_packer.sv
`timescale 1ns/1ps

module pair_packer
  import decode_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  logic [31:0] pc_i,
  input  logic [1:0]  mask_i,
  input  decode_rec_t rec0_i,
  input  decode_rec_t rec1_i,
  output logic        valid_o,
  input  logic        ready_i,
  output logic [1:0]  mask_o,
  output logic [31:0] pc0_o,
  output logic [31:0] pc1_o,
  output decode_rec_t rec0_o,
  output decode_rec_t rec1_o
);

  logic        accept;
  logic [31:0] slot1_pc;
  logic [1:0]  mask_d;
  logic [31:0] pc0_d;
  logic [31:0] pc1_d;
  decode_rec_t rec0_d;
  decode_rec_t rec1_d;

  // free when empty or drained this cycle, closed during flush
  assign ready_o = !flush_i && (!valid_o || ready_i);
  assign accept = valid_i && ready_o;

  assign slot1_pc = {pc_i[31:3], 1'b1, pc_i[1:0]};

  // move slot 1 down when slot 0 is empty
  always_comb
  begin
    mask_d = mask_i;
    pc0_d  = pc_i;
    pc1_d  = slot1_pc;
    rec0_d = rec0_i;
    rec1_d = rec1_i;
    if (mask_i == 2'b10)
    begin
      mask_d = 2'b01;
      pc0_d  = slot1_pc;
      rec0_d = rec1_i;
      pc1_d  = '0;
      rec1_d = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      valid_o <= 1'b0;
    end
    else if (accept)
    begin
      // an empty packet is consumed here and never shows
      valid_o <= |mask_i;
    end
    else if (ready_i)
    begin
      valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      mask_o <= mask_d;
      pc0_o  <= pc0_d;
      pc1_o  <= pc1_d;
      rec0_o <= rec0_d;
      rec1_o <= rec1_d;
    end
  end

  // stalled output must not change under the backend
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !flush_i |=>
      valid_o && $stable({mask_o, pc0_o, pc1_o, rec0_o, rec1_o})
  );

endmodule

// File: logic/slot_decoder.sv
`timescale 1ns/1ps

module slot_decoder
  import decode_pkg::*;
(
  input  inst_word_u  inst_i,
  output decode_rec_t rec_o
);

  logic [31:0] raw;
  logic [25:0] bl_offs;
  logic [31:0] imm12_sext;
  logic [31:0] bl_imm;
  op_class_t   op;

  assign raw = inst_i;

  // bl offset is split, high part sits in the low bits
  assign bl_offs = {raw[9:0], raw[25:10]};
  assign bl_imm = {{4{bl_offs[25]}}, bl_offs, 2'b00};

  assign imm12_sext = {{20{inst_i.imm_f.imm12[11]}}, inst_i.imm_f.imm12};

  // class from opcode fields
  always_comb
  begin
    op = OP_ILLEGAL;
    if (inst_i.reg_f.opcode == OPC_ADD_W)
    begin
      op = OP_ADD;
    end
    else if (inst_i.imm_f.opcode == OPC_ADDI_W)
    begin
      op = OP_ADDI;
    end
    else if (inst_i.imm_f.opcode == OPC_LD_W)
    begin
      op = OP_LOAD;
    end
    else if (inst_i.imm_f.opcode == OPC_ST_W)
    begin
      op = OP_STORE;
    end
    else if (raw[31:26] == OPC_BL)
    begin
      op = OP_BL;
    end
  end

  // register selection and immediate per class
  always_comb
  begin
    rec_o = '0;
    rec_o.op = op;
    case (op)
      OP_ADD :
      begin
        rec_o.r0_reg = inst_i.reg_f.rk;
        rec_o.r1_reg = inst_i.reg_f.rj;
        rec_o.w_reg  = inst_i.reg_f.rd;
      end
      OP_ADDI :
      begin
        rec_o.imm    = imm12_sext;
        rec_o.r1_reg = inst_i.reg_f.rj;
        rec_o.w_reg  = inst_i.reg_f.rd;
      end
      OP_LOAD :
      begin
        rec_o.imm    = imm12_sext;
        rec_o.r1_reg = inst_i.reg_f.rj;
        rec_o.w_reg  = inst_i.reg_f.rd;
      end
      OP_STORE :
      begin
        // store data comes from rd
        rec_o.imm    = imm12_sext;
        rec_o.r0_reg = inst_i.reg_f.rd;
        rec_o.r1_reg = inst_i.reg_f.rj;
      end
      OP_BL :
      begin
        rec_o.imm   = bl_imm;
        rec_o.w_reg = LINK_REG;
      end
      default :
      begin
        rec_o.ine = 1'b1;
      end
    endcase
  end

endmodule

// File: logic/decode_pkg.sv
package decode_pkg;

  // decoded operation class, one per supported instruction
  typedef enum logic [2:0] {
    OP_ILLEGAL = 3'd0,
    OP_ADD     = 3'd1,
    OP_ADDI    = 3'd2,
    OP_LOAD    = 3'd3,
    OP_STORE   = 3'd4,
    OP_BL      = 3'd5
  } op_class_t;

  // register format, as used by add.w
  typedef struct packed {
    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } inst_reg_fmt_t;

  // 12-bit immediate format for addi.w, ld.w and st.w
  typedef struct packed {
    logic [9:0]  opcode;
    logic [11:0] imm12;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } inst_imm_fmt_t;

  // one instruction word, two views of the same bits
  typedef union packed {
    inst_reg_fmt_t reg_f;
    inst_imm_fmt_t imm_f;
  } inst_word_u;

  // per-slot result of the decoder
  typedef struct packed {
    op_class_t   op;
    logic [31:0] imm;
    logic [4:0]  r0_reg;
    logic [4:0]  r1_reg;
    logic [4:0]  w_reg;
    logic        ine;
  } decode_rec_t;

  // opcode values of the decoded subset
  localparam logic [16:0] OPC_ADD_W  = 17'h00020;
  localparam logic [9:0]  OPC_ADDI_W = 10'h00A;
  localparam logic [9:0]  OPC_LD_W   = 10'h0A2;
  localparam logic [9:0]  OPC_ST_W   = 10'h0A6;
  localparam logic [5:0]  OPC_BL     = 6'h15;

  // bl writes the return address here
  localparam logic [4:0]  LINK_REG   = 5'd1;

endpackage

// File: logic/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// decode queue entries
`define DQ_DEPTH 4

// queue pointer width, log2 of the depth
`define DQ_PTR_W 2

`endif
